/* rs_pkg.sv */
`default_nettype none

package rs_pkg;

    // operand width of the integer channel
    parameter int xlen = 32;

    // reorder buffer tag, zero means the value is already valid
    typedef logic [3:0] tag_t;

    // alu function, as decoded upstream
    typedef enum logic [2:0] {
        alu_add = 3'd0,   // a + b
        alu_sub = 3'd1,   // a - b
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5    // signed compare, result 0 or 1
    } alu_op_e;

    // operand source at issue
    // bit 1 set -> operand a bypassed from the cdb
    // bit 0 set -> operand b bypassed from the cdb
    typedef enum logic [1:0] {
        reg_reg = 2'b00,  // both stored in the entry
        reg_cdb = 2'b01,  // b from the bus
        cdb_reg = 2'b10,  // a from the bus
        cdb_cdb = 2'b11   // both from the bus, same tag
    } bypass_e;

endpackage

`default_nettype wire

/* rs_entry.sv */
`default_nettype none

module rs_entry (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    squash,
    input  logic                    wr_en,        // one-hot slot from control
    input  logic                    clear,        // issued and accepted
    input  rs_pkg::alu_op_e         dispatch_op,
    input  rs_pkg::tag_t            dispatch_dest,
    input  rs_pkg::tag_t            rs1_tag,
    input  rs_pkg::tag_t            rs2_tag,
    input  logic [rs_pkg::xlen-1:0] rs1_value,
    input  logic [rs_pkg::xlen-1:0] rs2_value,
    input  logic                    cdb_valid,
    input  rs_pkg::tag_t            cdb_tag,
    input  logic [rs_pkg::xlen-1:0] cdb_value,
    output logic                    busy,
    output logic                    ready,
    output rs_pkg::bypass_e         flag,
    output rs_pkg::alu_op_e         entry_op,
    output rs_pkg::tag_t            entry_dest,
    output logic [rs_pkg::xlen-1:0] entry_opa,
    output logic [rs_pkg::xlen-1:0] entry_opb,
    output rs_pkg::tag_t            entry_tag_a,  // zero once operand a is held
    output rs_pkg::tag_t            entry_tag_b
);
    import rs_pkg::*;

    logic disp_hit_a;  // broadcast completes rs1 during the dispatch cycle
    logic disp_hit_b;
    logic wake_a;      // broadcast completes the stored tag a
    logic wake_b;

    // tag zero never matches, a zero tag is already a value
    assign disp_hit_a = cdb_valid && (rs1_tag != '0) && (cdb_tag == rs1_tag);
    assign disp_hit_b = cdb_valid && (rs2_tag != '0) && (cdb_tag == rs2_tag);

    assign wake_a = cdb_valid && (entry_tag_a != '0) && (cdb_tag == entry_tag_a);
    assign wake_b = cdb_valid && (entry_tag_b != '0) && (cdb_tag == entry_tag_b);

    // occupancy
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            busy <= 1'b0;            // squash wins over a same-cycle write
        end else if (wr_en) begin
            busy <= 1'b1;
        end else if (clear) begin
            busy <= 1'b0;            // slot usable again next edge
        end
    end

    // operation, tags and operand values
    always_ff @(posedge clock) begin
        if (wr_en) begin
            entry_op   <= dispatch_op;
            entry_dest <= dispatch_dest;
            // a match on the bus now counts as if the tag were zero
            entry_tag_a <= disp_hit_a ? tag_t'('0) : rs1_tag;
            entry_tag_b <= disp_hit_b ? tag_t'('0) : rs2_tag;
            entry_opa   <= disp_hit_a ? cdb_value : rs1_value;
            entry_opb   <= disp_hit_b ? cdb_value : rs2_value;
        end else if (busy) begin
            if (wake_a) begin
                entry_tag_a <= '0;
                entry_opa   <= cdb_value;   // hold it from here on
            end
            if (wake_b) begin
                entry_tag_b <= '0;
                entry_opb   <= cdb_value;
            end
        end
    end

    // ready counts the current broadcast, so issue can bypass the bus
    assign ready = busy
                && ((entry_tag_a == '0) || wake_a)
                && ((entry_tag_b == '0) || wake_b);

    // wake implies a nonzero tag, so bit set means the operand is not stored yet
    assign flag = bypass_e'({wake_a, wake_b});

endmodule

`default_nettype wire

/* rs_control.sv */
`default_nettype none

module rs_control #(
    parameter int n_entries = 4
) (
    input  logic                 clock,        // sampled by the bound checks
    input  logic                 rst,
    input  logic                 dispatch_valid,
    input  logic                 issue_ready,
    input  logic [n_entries-1:0] busy,
    input  logic [n_entries-1:0] ready,
    output logic [n_entries-1:0] wr_en,
    output logic [n_entries-1:0] clear,
    output logic [n_entries-1:0] issue_sel,
    output logic                 full,
    output logic                 issue_valid
);

    logic [n_entries-1:0] free;       // not busy
    logic [n_entries-1:0] alloc_sel;  // lowest free slot, one-hot

    // lowest set bit, one-hot, zero when no bit is set
    function automatic logic [n_entries-1:0] lowest_one(input logic [n_entries-1:0] req);
        logic [n_entries-1:0] grant;
        logic                 found;
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            if (req[i] && !found) begin
                grant[i] = 1'b1;
                found    = 1'b1;   // index 0 has priority
            end
        end
        return grant;
    endfunction

    assign free = ~busy;

    // full straight from the busy bits, no register
    assign full = &busy;

    // allocation side
    assign alloc_sel = lowest_one(free);
    assign wr_en     = (dispatch_valid && !full) ? alloc_sel : '0;

    // issue side, lowest ready index first
    assign issue_sel   = lowest_one(ready);
    assign issue_valid = |ready;

    // entry freed only when the unit takes it
    // with issue_ready low the same entry stays offered
    assign clear = issue_ready ? issue_sel : '0;

endmodule

`default_nettype wire

/* rs_issue_mux.sv */
`default_nettype none

module rs_issue_mux #(
    parameter int n_entries = 4
) (
    input  logic [n_entries-1:0]    issue_sel,              // one-hot or zero
    input  rs_pkg::alu_op_e         entry_op   [n_entries],
    input  rs_pkg::tag_t            entry_dest [n_entries],
    input  logic [rs_pkg::xlen-1:0] entry_opa  [n_entries],
    input  logic [rs_pkg::xlen-1:0] entry_opb  [n_entries],
    input  rs_pkg::bypass_e         flag       [n_entries],
    input  logic [rs_pkg::xlen-1:0] cdb_value,
    output rs_pkg::alu_op_e         issue_op,
    output rs_pkg::tag_t            issue_dest,
    output logic [rs_pkg::xlen-1:0] issue_opa,
    output logic [rs_pkg::xlen-1:0] issue_opb
);
    import rs_pkg::*;

    logic [2:0]      sel_op;     // and-or over the one-hot select
    tag_t            sel_dest;
    logic [xlen-1:0] sel_opa;
    logic [xlen-1:0] sel_opb;
    logic [1:0]      sel_flag;

    always_comb begin
        sel_op   = '0;
        sel_dest = '0;
        sel_opa  = '0;
        sel_opb  = '0;
        sel_flag = '0;           // reg_reg when nothing is chosen
        for (int i = 0; i < n_entries; i++) begin
            if (issue_sel[i]) begin
                sel_op   = sel_op   | entry_op[i];
                sel_dest = sel_dest | entry_dest[i];
                sel_opa  = sel_opa  | entry_opa[i];
                sel_opb  = sel_opb  | entry_opb[i];
                sel_flag = sel_flag | flag[i];
            end
        end
    end

    assign issue_op   = alu_op_e'(sel_op);
    assign issue_dest = sel_dest;

    // operand still on the bus this cycle, take it from there
    assign issue_opa = (bypass_e'(sel_flag) inside {cdb_reg, cdb_cdb}) ? cdb_value : sel_opa;
    assign issue_opb = (bypass_e'(sel_flag) inside {reg_cdb, cdb_cdb}) ? cdb_value : sel_opb;

endmodule

`default_nettype wire

/* reservation_station.sv */
`default_nettype none

module reservation_station #(
    parameter int n_entries = 4
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    squash,
    input  logic                    dispatch_valid,
    input  rs_pkg::alu_op_e         dispatch_op,
    input  rs_pkg::tag_t            dispatch_dest,
    input  rs_pkg::tag_t            rs1_tag,
    input  logic [rs_pkg::xlen-1:0] rs1_value,
    input  rs_pkg::tag_t            rs2_tag,
    input  logic [rs_pkg::xlen-1:0] rs2_value,
    output logic                    full,
    input  logic                    cdb_valid,
    input  rs_pkg::tag_t            cdb_tag,
    input  logic [rs_pkg::xlen-1:0] cdb_value,
    output logic                    issue_valid,
    output rs_pkg::alu_op_e         issue_op,
    output rs_pkg::tag_t            issue_dest,
    output logic [rs_pkg::xlen-1:0] issue_opa,
    output logic [rs_pkg::xlen-1:0] issue_opb,
    input  logic                    issue_ready
);
    import rs_pkg::*;

    logic [n_entries-1:0] wr_en;      // control -> entries
    logic [n_entries-1:0] clear;
    logic [n_entries-1:0] busy;       // entries -> control
    logic [n_entries-1:0] ready;
    logic [n_entries-1:0] issue_sel;  // control -> mux

    alu_op_e         entry_op   [n_entries];
    tag_t            entry_dest [n_entries];
    logic [xlen-1:0] entry_opa  [n_entries];
    logic [xlen-1:0] entry_opb  [n_entries];
    bypass_e         flag       [n_entries];

    for (genvar i = 0; i < n_entries; i++) begin : g_entry
        rs_entry i_entry (
            .clock(clock), .rst(rst), .squash(squash),
            .wr_en(wr_en[i]), .clear(clear[i]),
            .dispatch_op(dispatch_op), .dispatch_dest(dispatch_dest),
            .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
            .rs1_value(rs1_value), .rs2_value(rs2_value),
            .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
            .busy(busy[i]), .ready(ready[i]), .flag(flag[i]),
            .entry_op(entry_op[i]), .entry_dest(entry_dest[i]),
            .entry_opa(entry_opa[i]), .entry_opb(entry_opb[i]),
            .entry_tag_a(), .entry_tag_b()   // pending tags, waveform visibility only
        );
    end

    rs_control #(.n_entries(n_entries)) i_control (
        .clock(clock), .rst(rst),
        .dispatch_valid(dispatch_valid), .issue_ready(issue_ready),
        .busy(busy), .ready(ready),
        .wr_en(wr_en), .clear(clear), .issue_sel(issue_sel),
        .full(full), .issue_valid(issue_valid)
    );

    rs_issue_mux #(.n_entries(n_entries)) i_issue_mux (
        .issue_sel(issue_sel),
        .entry_op(entry_op), .entry_dest(entry_dest),
        .entry_opa(entry_opa), .entry_opb(entry_opb), .flag(flag),
        .cdb_value(cdb_value),
        .issue_op(issue_op), .issue_dest(issue_dest),
        .issue_opa(issue_opa), .issue_opb(issue_opb)
    );

endmodule

`default_nettype wire

/* rs_asserts.sv */
`default_nettype none

// bound into the top level, where squash meets the control outputs
module rs_asserts #(
    parameter int n_entries = 4
) (
    input logic                 clock,
    input logic                 rst,
    input logic                 squash,
    input logic                 full,
    input logic                 issue_valid,
    input logic [n_entries-1:0] wr_en,
    input logic [n_entries-1:0] issue_sel
);
    timeunit 1ns;
    timeprecision 1ps;

    // at most one entry offered to the unit
    a_sel_onehot: assert property (@(posedge clock) disable iff (rst) $onehot0(issue_sel))
        else $error("issue_sel has more than one bit set: %b", issue_sel);

    a_no_write_full: assert property (@(posedge clock) disable iff (rst) full |-> (wr_en == '0))
        else $error("entry written while the station is full");

    // squash empties every entry, nothing left to offer
    a_squash_empty: assert property (@(posedge clock) disable iff (rst) squash |=> !issue_valid)
        else $error("issue_valid high in the cycle after a squash");

endmodule

bind reservation_station rs_asserts #(.n_entries(n_entries)) i_asserts (
    .clock(clock), .rst(rst), .squash(squash), .full(full),
    .issue_valid(issue_valid), .wr_en(wr_en), .issue_sel(issue_sel)
);

`default_nettype wire

/* rs_tb.sv */
`default_nettype none

module rs_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rs_pkg::*;

    localparam int          n_rows      = 15;
    localparam int          wait_limit  = 64;            // cycles any single wait may take
    localparam logic [31:0] seed        = 32'he2c9a9a1;
    localparam int          st_idle     = 0;
    localparam int          st_pending  = 1;
    localparam int          st_issued   = 2;
    localparam int          st_squashed = 3;

    typedef struct {
        alu_op_e         op;
        tag_t            dest;
        tag_t            tag1;
        tag_t            tag2;
        int              delay;     // dispatch to broadcast in cycles, -1 for none
        logic [xlen-1:0] val1;
        logic [xlen-1:0] val2;
        logic [xlen-1:0] cdb_val;
        logic [xlen-1:0] exp_a;     // operand the unit must see
        logic [xlen-1:0] exp_b;
    } row_t;

    logic            clock, rst, squash, dispatch_valid, cdb_valid, issue_ready;
    logic            full, issue_valid;
    alu_op_e         dispatch_op, issue_op;
    tag_t            dispatch_dest, rs1_tag, rs2_tag, cdb_tag, issue_dest;
    logic [xlen-1:0] rs1_value, rs2_value, cdb_value, issue_opa, issue_opb;

    row_t            rows [n_rows];
    int              state [16];    // scoreboard, indexed by dest tag
    logic            woken [16];    // every tagged operand has been on the bus
    alu_op_e         sb_op [16];
    logic [xlen-1:0] sb_a [16];
    logic [xlen-1:0] sb_b [16];
    logic [31:0]     rng;
    logic [31:0]     ready_rng;
    int              issue_mode;    // 0 random, 1 always ready, 2 stalled
    int              mismatch_errors, other_errors, n_accepted, n_issued, n_squashed;
    tag_t            mon_dest;

    reservation_station #(.n_entries(4)) i_dut (.*);

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        mismatch_errors++;
    endtask

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) report_mismatch(name, xlen'(got), xlen'(exp));
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) report_mismatch(name, xlen'(got), xlen'(exp));
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, xlen'(got), xlen'(exp));
    endtask

    // one table row, dest tags run 1..15, tagged operands expect the bus value
    task automatic set_row(input int i, input alu_op_e op, input tag_t t1, input tag_t t2,
                           input int delay);
        rows[i].op    = op;
        rows[i].dest  = tag_t'(i + 1);
        rows[i].tag1  = t1;
        rows[i].tag2  = t2;
        rows[i].delay = delay;
        rng = xorshift(rng);
        rows[i].val1 = rng;
        rng = xorshift(rng);
        rows[i].val2 = rng;
        rng = xorshift(rng);
        rows[i].cdb_val = rng;
        rows[i].exp_a = (t1 != '0) ? rows[i].cdb_val : rows[i].val1;
        rows[i].exp_b = (t2 != '0) ? rows[i].cdb_val : rows[i].val2;
    endtask

    task automatic change_mode(input int m);
        @(posedge clock);
        issue_mode = m;   // ready driver picks it up at the next falling edge
    endtask

    task automatic apply_row(input int i);
        int   waited;
        tag_t d;
        tag_t btag;
        waited = 0;
        d      = rows[i].dest;
        btag   = (rows[i].tag1 != '0) ? rows[i].tag1 : rows[i].tag2;
        @(negedge clock);
        dispatch_valid = 1'b1;
        dispatch_op    = rows[i].op;
        dispatch_dest  = d;
        rs1_tag        = rows[i].tag1;
        rs1_value      = rows[i].val1;
        rs2_tag        = rows[i].tag2;
        rs2_value      = rows[i].val2;
        while (full && waited < wait_limit) begin   // source holds while full
            @(negedge clock);
            waited++;
        end
        if (full) begin
            $display("timeout: dispatch of dest %0d was never accepted", d);
            other_errors++;
            dispatch_valid = 1'b0;
        end else begin
            if (rows[i].delay == 0 && btag != '0) begin   // broadcast in the dispatch cycle
                cdb_valid = 1'b1;
                cdb_tag   = btag;
                cdb_value = rows[i].cdb_val;
            end
            state[d] = st_pending;
            woken[d] = (btag == '0) || (rows[i].delay == 0);
            sb_op[d] = rows[i].op;
            sb_a[d]  = rows[i].exp_a;
            sb_b[d]  = rows[i].exp_b;
            n_accepted++;
            @(negedge clock);
            dispatch_valid = 1'b0;
            cdb_valid      = 1'b0;
            if (rows[i].delay > 0 && btag != '0) begin
                repeat (rows[i].delay - 1) @(negedge clock);
                cdb_valid = 1'b1;
                cdb_tag   = btag;
                cdb_value = rows[i].cdb_val;
                woken[d]  = 1'b1;
                @(negedge clock);
                cdb_valid = 1'b0;
                // unit ready, so it went out on the bypass
                if (issue_mode == 1 && state[d] != st_issued) begin
                    $display("dest %0d did not issue in its broadcast cycle", d);
                    other_errors++;
                end
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (n_issued != n_accepted - n_squashed && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (n_issued != n_accepted - n_squashed) begin
            $display("timeout: accepted operations did not all issue");
            other_errors++;
        end
    endtask

    // functional unit back-pressure
    initial begin
        issue_ready = 1'b0;
        ready_rng   = seed;
        forever begin
            @(negedge clock);
            if (issue_mode == 0) begin
                ready_rng   = xorshift(ready_rng);
                issue_ready = ready_rng[0];
            end else begin
                issue_ready = (issue_mode == 1);
            end
        end
    end

    // issue monitor, mid low phase where outputs have settled
    initial begin
        forever begin
            @(negedge clock);
            #10;
            if (!rst && issue_valid && issue_ready) begin
                mon_dest = issue_dest;
                if (state[mon_dest] != st_pending) begin
                    $display("dest %0d issued while not waiting to issue", mon_dest);
                    other_errors++;
                end else begin
                    if (!woken[mon_dest]) begin
                        $display("dest %0d issued before its operands were broadcast", mon_dest);
                        other_errors++;
                    end
                    check_op("issue_op", issue_op, sb_op[mon_dest]);
                    check_value("issue_opa", issue_opa, sb_a[mon_dest]);
                    check_value("issue_opb", issue_opb, sb_b[mon_dest]);
                    state[mon_dest] = st_issued;
                    n_issued++;
                end
            end
        end
    end

    initial begin
        #(wait_limit * 200 * 40);
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        squash = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op = alu_add;
        dispatch_dest = '0;
        rs1_tag = '0;
        rs1_value = '0;
        rs2_tag = '0;
        rs2_value = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        issue_mode = 0;
        rng = xorshift(seed);
        mismatch_errors = 0;
        other_errors = 0;
        n_accepted = 0;
        n_issued = 0;
        n_squashed = 0;
        for (int d = 0; d < 16; d++) begin
            state[d] = st_idle;
            woken[d] = 1'b0;
        end
        set_row(0, alu_add, 4'd0, 4'd0, -1);    // operands valid at dispatch
        set_row(1, alu_sub, 4'd0, 4'd0, -1);
        set_row(2, alu_slt, 4'd0, 4'd0, -1);
        set_row(3, alu_and, 4'd1, 4'd0, 2);     // later wakeup of a
        set_row(4, alu_or,  4'd0, 4'd2, 1);     // later wakeup of b
        set_row(5, alu_xor, 4'd3, 4'd3, 3);     // both on one broadcast
        set_row(6, alu_add, 4'd4, 4'd0, 0);     // captured while dispatched
        set_row(7, alu_sub, 4'd5, 4'd5, 0);
        set_row(8, alu_and, 4'd0, 4'd0, -1);    // fills the station under stall
        set_row(9, alu_or,  4'd0, 4'd0, -1);
        set_row(10, alu_xor, 4'd0, 4'd0, -1);
        set_row(11, alu_slt, 4'd0, 4'd0, -1);
        set_row(12, alu_add, 4'd0, 4'd0, -1);   // fifth request, has to wait
        set_row(13, alu_and, 4'd6, 4'd0, -1);   // never woken before squash
        set_row(14, alu_or,  4'd0, 4'd7, -1);
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        check_bit("full", full, 1'b0);
        check_bit("issue_valid", issue_valid, 1'b0);
        check_tag("issue_dest", issue_dest, '0);
        for (int i = 0; i < 3; i++) apply_row(i);
        wait_drained();
        change_mode(1);
        for (int i = 3; i < 8; i++) apply_row(i);
        wait_drained();
        change_mode(2);
        for (int i = 8; i < 12; i++) apply_row(i);
        check_bit("full", full, 1'b1);
        fork
            apply_row(12);
            begin
                repeat (3) @(negedge clock);
                check_bit("full", full, 1'b1);                   // fifth request still held
                check_bit("issue_valid", issue_valid, 1'b1);
                check_tag("issue_dest", issue_dest, rows[8].dest);  // entry 0 kept on offer
                change_mode(0);
            end
        join
        wait_drained();
        apply_row(13);
        apply_row(14);
        @(negedge clock);
        squash = 1'b1;
        for (int d = 0; d < 16; d++) begin
            if (state[d] == st_pending) begin
                state[d] = st_squashed;
                n_squashed++;
            end
        end
        @(negedge clock);
        squash = 1'b0;
        check_bit("full", full, 1'b0);
        check_bit("issue_valid", issue_valid, 1'b0);
        check_tag("issue_dest", issue_dest, '0);
        cdb_valid = 1'b1;                       // late wakeups hit empty entries
        cdb_tag   = rows[13].tag1;
        cdb_value = rows[13].cdb_val;
        @(negedge clock);
        cdb_tag = rows[14].tag2;
        @(negedge clock);
        cdb_valid = 1'b0;
        repeat (4) @(negedge clock);
        for (int d = 1; d < 16; d++) begin
            if (state[d] == st_pending || state[d] == st_idle) begin
                $display("dest %0d was never issued", d);
                other_errors++;
            end
        end
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* reservation_station.f */
rs_pkg.sv
rs_entry.sv
rs_control.sv
rs_issue_mux.sv
reservation_station.sv
rs_asserts.sv
rs_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module rs_tb \
    -f reservation_station.f -o rs_sim
out=$(./obj_dir/rs_sim) || true
echo "$out"
if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
